/* Makefile */
# Verilator build and run of the store path testbench

VERILATOR ?= verilator
TOP       ?= tb_ofm_store
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/ofm_store_ctrl.sv */
// ********************
// tile store sequencer: clips the tile at
// the map edges, forms row burst addresses
// and hands bursts to the write master
// ********************
`default_nettype none

module ofm_store_ctrl #(
    parameter int n  = 8,
    parameter int r  = 12,
    parameter int c  = 10,
    parameter int tn = 4,
    parameter int tr = 6,
    parameter int tc = 6,
    parameter int s  = 1,
    parameter int k  = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          store_start,
    input  ofm_store_pkg::tile_cfg_t      cfg,
    input  logic                          fifo_empty,
    input  logic                          trans_done,
    input  logic [ofm_store_pkg::cw-1:0]  cnt_row,
    input  logic [ofm_store_pkg::cw-1:0]  cnt_ch,
    input  logic                          cnt_last,
    output logic                          store_done,
    output logic                          cnt_step,
    output logic [ofm_store_pkg::cw-1:0]  row_len,
    output logic [ofm_store_pkg::cw-1:0]  ch_len,
    output logic                          trans_start,
    output ofm_store_pkg::burst_cmd_t     cmd
);
    import ofm_store_pkg::*;

    localparam int row_step = ((tr + s - k) / s) * s;
    localparam int col_step = ((tc + s - k) / s) * s;
    localparam int r_step   = ((r + s - k) / s) * s;

    typedef enum logic [2:0] {st_idle, st_wait, st_config, st_trans, st_done} state_t;

    state_t        state;
    logic          is_last;
    logic [dw-1:0] word_off;

    assign cnt_step = state == st_config;  // one step per burst

    // word offset of the current row burst inside the output map
    assign word_off = (dw'(cfg.base_n) + dw'(cnt_ch)) * dw'(r * c)
                    + (dw'(cfg.base_row) + dw'(cnt_row)) * dw'(c)
                    + dw'(cfg.base_col);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   if (store_start) state <= fifo_empty ? st_wait : st_config;
                st_wait:   if (!fifo_empty) state <= st_config;
                st_config: state <= st_trans;
                st_trans: begin
                    if (trans_done) begin
                        if (is_last)         state <= st_done;
                        else if (fifo_empty) state <= st_wait;
                        else                 state <= st_config;
                    end
                end
                default:   state <= st_idle; // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ch_len      <= '0;
            row_len     <= '0;
            is_last     <= 1'b0;
            trans_start <= 1'b0;
            store_done  <= 1'b0;
        end else begin
            trans_start <= state == st_config;
            store_done  <= state == st_done;
            if (store_start && state == st_idle) begin
                ch_len  <= (cfg.base_n + cw'(tn) < cw'(n)) ? cw'(tn) : cw'(n) - cfg.base_n;
                row_len <= (cfg.base_row + cw'(row_step) <= cw'(r_step)) ?
                           cw'(row_step) : cw'(r_step) - cfg.base_row;
                is_last <= 1'b0;
            end else if (cnt_last) begin
                is_last <= 1'b1;            // final burst of the tile is on its way
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_config) begin
            cmd.addr <= cfg.out_base + (word_off << 2);
            cmd.len  <= cw'(col_step);
        end
    end

    a_start_after_config: assert property (@(posedge clk) disable iff (rst)
        trans_start |-> $past(state == st_config));

endmodule

`default_nettype wire

/* hdl/ofm_store_fifo.sv */
// ********************
// synchronous store FIFO between the
// compute stream and the write master
// ********************
`default_nettype none

module ofm_store_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  logic [ofm_store_pkg::dw-1:0]  push_data,
    output logic                          full,
    input  logic                          pop,
    output logic [ofm_store_pkg::dw-1:0]  pop_data,
    output logic                          empty
);
    import ofm_store_pkg::*;

    localparam int aw = $clog2(fifo_depth);

    logic [dw-1:0] mem [fifo_depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;

    assign full     = count == (aw+1)'(fifo_depth);
    assign empty    = count == '0;
    assign pop_data = mem[rd_ptr];        // head word shows while not empty

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == aw'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == aw'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (aw+1)'(push) - (aw+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

/* hdl/ofm_store_pkg.sv */
// ********************
// shared widths, packed structs and the
// AXI4-Lite register map of the output
// feature map store path
// ********************
`default_nettype none

package ofm_store_pkg;

    localparam int dw = 32;                 // data and address width
    localparam int cw = 16;                 // tile coordinate and count width

    typedef struct packed {
        logic [cw-1:0] base_n;              // first output channel of the tile
        logic [cw-1:0] base_row;
        logic [cw-1:0] base_col;
        logic [dw-1:0] out_base;            // byte address of the output map
    } tile_cfg_t;

    typedef struct packed {
        logic [dw-1:0] addr;                // byte address of the first word
        logic [cw-1:0] len;                 // burst length in words
    } burst_cmd_t;

    typedef struct packed {
        logic [dw-1:0] addr;
        logic [dw-1:0] data;
    } mem_wr_t;

    localparam logic [dw-1:0] reg_ctrl     = 32'h00; // bit 0 starts a store
    localparam logic [dw-1:0] reg_status   = 32'h04; // bit 0 busy, bit 1 done
    localparam logic [dw-1:0] reg_base_n   = 32'h08;
    localparam logic [dw-1:0] reg_base_row = 32'h0C;
    localparam logic [dw-1:0] reg_base_col = 32'h10;
    localparam logic [dw-1:0] reg_out_base = 32'h14;
    localparam logic [dw-1:0] reg_tile_cnt = 32'h18; // completed tiles, read only

endpackage

`default_nettype wire

/* hdl/ofm_store_regs.sv */
// ********************
// AXI4-Lite register block: tile
// configuration, start pulse, busy and
// sticky done status, tile counter
// ********************
`default_nettype none

module ofm_store_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [ofm_store_pkg::dw-1:0]    awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [ofm_store_pkg::dw-1:0]    wdata,
    input  logic [ofm_store_pkg::dw/8-1:0]  wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [ofm_store_pkg::dw-1:0]    araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [ofm_store_pkg::dw-1:0]    rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    output ofm_store_pkg::tile_cfg_t        cfg,
    output logic                            store_start,
    input  logic                            store_done,
    output logic                            done
);
    import ofm_store_pkg::*;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    logic          wr_en;
    logic          rd_en;
    logic          busy;
    logic [dw-1:0] tile_cnt;

    // byte lane merge of a register write
    function automatic logic [dw-1:0] merge(input logic [dw-1:0] old,
                                            input logic [dw-1:0] din,
                                            input logic [dw/8-1:0] strb);
        logic [dw-1:0] res;
        res = old;
        for (int i = 0; i < dw/8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = din[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic mapped(input logic [dw-1:0] a);
        return a inside {reg_ctrl, reg_status, reg_base_n, reg_base_row,
                         reg_base_col, reg_out_base, reg_tile_cnt};
    endfunction

    assign wr_en   = awvalid && wvalid && !bvalid; // address and data taken together
    assign awready = wr_en;
    assign wready  = wr_en;
    assign rd_en   = arvalid && !rvalid;
    assign arready = !rvalid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= resp_okay;
        end else if (wr_en) begin
            bvalid <= 1'b1;
            bresp  <= mapped(awaddr) ? resp_okay : resp_slverr;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg <= '0;
        end else if (wr_en) begin
            case (awaddr)
                reg_base_n:   cfg.base_n   <= cw'(merge(dw'(cfg.base_n), wdata, wstrb));
                reg_base_row: cfg.base_row <= cw'(merge(dw'(cfg.base_row), wdata, wstrb));
                reg_base_col: cfg.base_col <= cw'(merge(dw'(cfg.base_col), wdata, wstrb));
                reg_out_base: cfg.out_base <= merge(cfg.out_base, wdata, wstrb);
                default: ;
            endcase
        end
    end

    // start only when idle, a pending pulse counts as busy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            store_start <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
            tile_cnt    <= '0;
        end else begin
            store_start <= wr_en && awaddr == reg_ctrl && wstrb[0] && wdata[0]
                           && !busy && !store_start;
            if (store_start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (store_done) begin
                busy     <= 1'b0;
                done     <= 1'b1;           // sticky until the next start
                tile_cnt <= tile_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
            rresp  <= resp_okay;
            rdata  <= '0;
        end else if (rd_en) begin
            rvalid <= 1'b1;
            rresp  <= mapped(araddr) ? resp_okay : resp_slverr;
            case (araddr)
                reg_status:   rdata <= dw'({done, busy});
                reg_base_n:   rdata <= dw'(cfg.base_n);
                reg_base_row: rdata <= dw'(cfg.base_row);
                reg_base_col: rdata <= dw'(cfg.base_col);
                reg_out_base: rdata <= cfg.out_base;
                reg_tile_cnt: rdata <= tile_cnt;
                default:      rdata <= '0;  // ctrl and unmapped read as zero
            endcase
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

/* hdl/ofm_store_top.sv */
// ********************
// store path top level: register block,
// sequencer, tile counter, FIFO and
// write master
// ********************
`default_nettype none

module ofm_store_top #(
    parameter int n          = 8,
    parameter int r          = 12,
    parameter int c          = 10,
    parameter int tn         = 4,
    parameter int tr         = 6,
    parameter int tc         = 6,
    parameter int s          = 1,
    parameter int k          = 3,
    parameter int fifo_depth = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [ofm_store_pkg::dw-1:0]    awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [ofm_store_pkg::dw-1:0]    wdata,
    input  logic [ofm_store_pkg::dw/8-1:0]  wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [ofm_store_pkg::dw-1:0]    araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [ofm_store_pkg::dw-1:0]    rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    input  logic                            ofm_valid,
    input  logic [ofm_store_pkg::dw-1:0]    ofm_data,
    output logic                            ofm_ready,
    output logic                            mem_wr_valid,
    output ofm_store_pkg::mem_wr_t          mem_wr,
    input  logic                            mem_wr_ready,
    output logic                            done
);
    import ofm_store_pkg::*;

    tile_cfg_t     cfg;
    burst_cmd_t    cmd;
    logic          store_start, store_done;
    logic          trans_start, trans_done;
    logic          fifo_full, fifo_empty, fifo_pop;
    logic [dw-1:0] fifo_data;
    logic          cnt_step, cnt_last;
    logic [cw-1:0] row_len, ch_len, cnt_row, cnt_ch;

    assign ofm_ready = !fifo_full;

    ofm_store_regs u_regs (
        .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
        .rvalid, .rready, .cfg, .store_start, .store_done, .done
    );

    ofm_store_ctrl #(
        .n(n), .r(r), .c(c), .tn(tn), .tr(tr), .tc(tc), .s(s), .k(k)
    ) u_ctrl (
        .clk, .rst, .store_start, .cfg, .fifo_empty, .trans_done, .cnt_row, .cnt_ch,
        .cnt_last, .store_done, .cnt_step, .row_len, .ch_len, .trans_start, .cmd
    );

    ofm_tile_counter u_counter (
        .clk, .rst, .clear(store_done), .step(cnt_step), .row_max(row_len),
        .ch_max(ch_len), .cnt_row, .cnt_ch, .last(cnt_last)
    );

    ofm_store_fifo #(.fifo_depth(fifo_depth)) u_fifo (
        .clk, .rst, .push(ofm_valid && ofm_ready), .push_data(ofm_data),
        .full(fifo_full), .pop(fifo_pop), .pop_data(fifo_data), .empty(fifo_empty)
    );

    ofm_write_master u_wmst (
        .clk, .rst, .trans_start, .cmd, .trans_done, .fifo_pop, .fifo_data,
        .fifo_empty, .mem_wr_valid, .mem_wr, .mem_wr_ready
    );

endmodule

`default_nettype wire

/* hdl/ofm_tile_counter.sv */
// ********************
// row inside channel counter for
// the bursts of one tile
// ********************
`default_nettype none

module ofm_tile_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear,
    input  logic                          step,
    input  logic [ofm_store_pkg::cw-1:0]  row_max,
    input  logic [ofm_store_pkg::cw-1:0]  ch_max,
    output logic [ofm_store_pkg::cw-1:0]  cnt_row,
    output logic [ofm_store_pkg::cw-1:0]  cnt_ch,
    output logic                          last
);

    logic row_end;
    logic ch_end;

    assign row_end = cnt_row == row_max - 1'b1;
    assign ch_end  = cnt_ch == ch_max - 1'b1;
    assign last    = step && row_end && ch_end; // final burst is being stepped

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_row <= '0;
            cnt_ch  <= '0;
        end else if (clear) begin
            cnt_row <= '0;
            cnt_ch  <= '0;
        end else if (step) begin
            if (row_end) begin
                cnt_row <= '0;
                cnt_ch  <= ch_end ? '0 : cnt_ch + 1'b1;
            end else begin
                cnt_row <= cnt_row + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/ofm_write_master.sv */
// ********************
// burst writer from the store FIFO
// to the memory write port
// ********************
`default_nettype none

module ofm_write_master (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          trans_start,
    input  ofm_store_pkg::burst_cmd_t     cmd,
    output logic                          trans_done,
    output logic                          fifo_pop,
    input  logic [ofm_store_pkg::dw-1:0]  fifo_data,
    input  logic                          fifo_empty,
    output logic                          mem_wr_valid,
    output ofm_store_pkg::mem_wr_t        mem_wr,
    input  logic                          mem_wr_ready
);
    import ofm_store_pkg::*;

    logic          active;
    logic [dw-1:0] addr;
    logic [cw-1:0] remain;                 // words still to write

    assign mem_wr_valid = active && !fifo_empty;
    assign fifo_pop     = mem_wr_valid && mem_wr_ready;
    assign mem_wr.addr  = addr;
    assign mem_wr.data  = fifo_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active     <= 1'b0;
            trans_done <= 1'b0;
            addr       <= '0;
            remain     <= '0;
        end else begin
            trans_done <= 1'b0;
            if (trans_start) begin
                active <= 1'b1;
                addr   <= cmd.addr;
                remain <= cmd.len;
            end else if (fifo_pop) begin
                addr   <= addr + dw'(4);
                remain <= remain - 1'b1;
                if (remain == cw'(1)) begin
                    active     <= 1'b0;
                    trans_done <= 1'b1;     // last beat taken
                end
            end
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_wr_valid && !mem_wr_ready |=> $stable(mem_wr.addr));

endmodule

`default_nettype wire

/* project.f */
+incdir+test
hdl/ofm_store_pkg.sv
hdl/ofm_tile_counter.sv
hdl/ofm_store_fifo.sv
hdl/ofm_write_master.sv
hdl/ofm_store_ctrl.sv
hdl/ofm_store_regs.sv
hdl/ofm_store_top.sv
test/tb_ofm_store.sv

/* test/ofm_store_ref.svh */
// ********************
// expected clipped tile counts, burst
// addresses and lengths, and the
// value check of the testbench
// ********************
`ifndef ofm_store_ref_svh
`define ofm_store_ref_svh

// channels in a tile after clipping at the last channel of the map
function automatic int ref_ch_len(input tile_cfg_t t);
    return (int'(t.base_n) + tile_n < map_n) ? tile_n : map_n - int'(t.base_n);
endfunction

// rows in a tile after clipping at the last output row
function automatic int ref_row_len(input tile_cfg_t t);
    int row_step;
    int map_step;
    row_step = ((tile_r + stride - kernel) / stride) * stride;
    map_step = ((map_r + stride - kernel) / stride) * stride;
    return (int'(t.base_row) + row_step <= map_step) ? row_step : map_step - int'(t.base_row);
endfunction

// burst b of a tile, rows inner and channels outer
function automatic burst_cmd_t ref_burst(input tile_cfg_t t, input int b);
    burst_cmd_t cmd;
    int ch;
    int row;
    int word;
    ch       = b / ref_row_len(t);
    row      = b % ref_row_len(t);
    word     = (int'(t.base_n) + ch) * map_r * map_c
             + (int'(t.base_row) + row) * map_c + int'(t.base_col);
    cmd.addr = t.out_base + 32'(4 * word);                   // byte address
    cmd.len  = 16'(((tile_c + stride - kernel) / stride) * stride);
    return cmd;
endfunction

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first mismatch");
    end
endtask

`endif

/* test/tb_ofm_store.sv */
// ********************
// testbench of the store path: clock and reset,
// AXI4-Lite tasks, stream driver, memory model,
// beat checker and cycle limit
// ********************
`default_nettype none

module tb_ofm_store;
    timeunit 1ns;
    timeprecision 100ps;
    import ofm_store_pkg::*;

    localparam int map_n      = 8;
    localparam int map_r      = 12;
    localparam int map_c      = 10;
    localparam int tile_n     = 4;
    localparam int tile_r     = 6;
    localparam int tile_c     = 6;
    localparam int stride     = 1;
    localparam int kernel     = 3;
    localparam int fifo_depth = 16;
    localparam int max_cycles = 20000;      // 208 words times a stall factor of 8 plus margin

    logic          clk = 1'b0;
    logic          rst;
    logic [dw-1:0] awaddr;
    logic          awvalid;
    logic          awready;
    logic [dw-1:0] wdata;
    logic [3:0]    wstrb;
    logic          wvalid;
    logic          wready;
    logic [1:0]    bresp;
    logic          bvalid;
    logic          bready;
    logic [dw-1:0] araddr;
    logic          arvalid;
    logic          arready;
    logic [dw-1:0] rdata;
    logic [1:0]    rresp;
    logic          rvalid;
    logic          rready;
    logic          ofm_valid;
    logic [dw-1:0] ofm_data;
    logic          ofm_ready;
    logic          mem_wr_valid;
    mem_wr_t       mem_wr;
    logic          mem_wr_ready;
    logic          done;

    integer        seed = 32'he630;
    logic          gaps_on;                 // random stream and memory stalls
    logic          fire;
    logic [dw-1:0] word_num;                // stream word on offer
    logic [dw-1:0] next_word;               // word expected at the memory port
    logic [dw-1:0] exp_addr[$];
    int            exp_beats;
    int            tile_beats;
    int            tiles_done;
    int            cycles;
    logic [1:0]    resp;
    logic [dw-1:0] rd_val;
    tile_cfg_t     tile;

    `include "ofm_store_ref.svh"

    ofm_store_top #(
        .n(map_n), .r(map_r), .c(map_c), .tn(tile_n), .tr(tile_r), .tc(tile_c),
        .s(stride), .k(kernel), .fifo_depth(fifo_depth)
    ) uut (
        .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
        .rvalid, .rready, .ofm_valid, .ofm_data, .ofm_ready, .mem_wr_valid, .mem_wr,
        .mem_wr_ready, .done
    );

    always #4 clk = ~clk;

    // stream driver and memory model draw from one random sequence
    initial begin
        ofm_valid    = 1'b0;
        ofm_data     = '0;
        mem_wr_ready = 1'b0;
        word_num     = '0;
        forever begin
            @(negedge clk);
            fire = ofm_valid && ofm_ready;
            @(posedge clk);
            #1;
            if (fire) word_num = word_num + 1;
            ofm_data = word_num;
            if (rst) begin
                ofm_valid    = 1'b0;
                mem_wr_ready = 1'b0;
            end else begin
                if (!ofm_valid || fire) ofm_valid = !gaps_on || (($random(seed) & 3) != 0);
                mem_wr_ready = !gaps_on || (($random(seed) & 3) != 0);
            end
        end
    end

    // every accepted beat against the queued address and the stream order
    always @(negedge clk) begin
        if (!rst && mem_wr_valid && mem_wr_ready) begin
            if (exp_addr.size() == 0) begin
                $display("[FAIL] t=%0t memory beat at %h while none was expected",
                         $time, mem_wr.addr);
                $display("CHECKS FAILED");
                $fatal(1, "unexpected memory write");
            end else begin
                check_value("beat address", mem_wr.addr, exp_addr.pop_front());
                check_value("beat data", mem_wr.data, next_word);
                next_word  = next_word + 1;
                tile_beats = tile_beats + 1;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("CHECKS FAILED");
        $fatal(1, "stopped by the cycle limit");
    end

    task automatic axi_write(input logic [dw-1:0] addr, input logic [dw-1:0] data,
                             output logic [1:0] rsp);
        @(posedge clk);
        #1;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hf;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check_value("write data ready with address ready", 32'(wready), 32'h1);
        @(posedge clk);                     // address and data taken here
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        rsp = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [dw-1:0] addr, output logic [dw-1:0] data,
                            output logic [1:0] rsp);
        @(posedge clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        rsp  = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic write_reg(input logic [dw-1:0] addr, input logic [dw-1:0] data);
        logic [1:0] rsp;
        axi_write(addr, data, rsp);
        check_value("write response", 32'(rsp), 32'h0);
    endtask

    task automatic read_expect(input logic [dw-1:0] addr, input logic [dw-1:0] exp);
        logic [1:0]    rsp;
        logic [dw-1:0] data;
        axi_read(addr, data, rsp);
        check_value("read response", 32'(rsp), 32'h0);
        check_value("read data", data, exp);
    endtask

    // program a tile, queue its beats and start it
    task automatic run_tile(input tile_cfg_t t);
        burst_cmd_t cmd;
        int         bursts;
        write_reg(reg_base_n, 32'(t.base_n));
        write_reg(reg_base_row, 32'(t.base_row));
        write_reg(reg_base_col, 32'(t.base_col));
        write_reg(reg_out_base, t.out_base);
        bursts = ref_ch_len(t) * ref_row_len(t);
        for (int b = 0; b < bursts; b++) begin
            cmd = ref_burst(t, b);
            for (int w = 0; w < int'(cmd.len); w++) begin
                exp_addr.push_back(cmd.addr + 32'(4 * w));
            end
        end
        exp_beats  = exp_addr.size();
        tile_beats = 0;
        write_reg(reg_ctrl, 32'h1);
        check_value("done after start", 32'(done), 32'h0);
        read_expect(reg_status, 32'h1);     // busy, done clear
    endtask

    task automatic finish_tile();
        while (!done) @(negedge clk);
        tiles_done++;
        check_value("beats of the tile", 32'(tile_beats), 32'(exp_beats));
        check_value("beats still missing", 32'(exp_addr.size()), 32'h0);
        read_expect(reg_status, 32'h2);
        read_expect(reg_tile_cnt, 32'(tiles_done));
    endtask

    initial begin
        rst        = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        gaps_on    = 1'b0;
        next_word  = '0;
        tile_beats = 0;
        tiles_done = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("done after reset", 32'(done), 32'h0);
        check_value("write valid after reset", 32'(mem_wr_valid), 32'h0);

        read_expect(reg_status, 32'h0);
        read_expect(reg_tile_cnt, 32'h0);
        write_reg(reg_base_n, 32'h3);
        write_reg(reg_base_row, 32'h5);
        write_reg(reg_base_col, 32'h7);
        write_reg(reg_out_base, 32'hdead_beec);
        read_expect(reg_base_n, 32'h3);
        read_expect(reg_base_row, 32'h5);
        read_expect(reg_base_col, 32'h7);
        read_expect(reg_out_base, 32'hdead_beec);
        axi_write(32'h1c, 32'h5a5a, resp);
        check_value("unmapped write response", 32'(resp), 32'h2);
        axi_read(32'h1c, rd_val, resp);
        check_value("unmapped read response", 32'(resp), 32'h2);
        check_value("unmapped read data", rd_val, 32'h0);

        tile = '{base_n: 16'd0, base_row: 16'd0, base_col: 16'd0, out_base: 32'h1000};
        run_tile(tile);                     // interior tile
        finish_tile();
        tile = '{base_n: 16'd6, base_row: 16'd8, base_col: 16'd4, out_base: 32'h1000};
        run_tile(tile);                     // clipped at both map edges
        finish_tile();

        @(negedge clk);
        gaps_on = 1'b1;
        tile = '{base_n: 16'd4, base_row: 16'd4, base_col: 16'd2, out_base: 32'h8000};
        run_tile(tile);
        finish_tile();

        // second start while busy must be dropped
        tile = '{base_n: 16'd2, base_row: 16'd0, base_col: 16'd6, out_base: 32'h4000};
        run_tile(tile);
        write_reg(reg_ctrl, 32'h1);
        read_expect(reg_status, 32'h1);
        finish_tile();
        repeat (100) @(posedge clk);        // window for a stray second tile
        read_expect(reg_tile_cnt, 32'(tiles_done));

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
